// File: udma_pkg.sv
// shared constants; RX_FIFO_DEPTH must be a power of two, transfers are whole 32-bit words
package udma_pkg;

    localparam int L2_ADDR_WIDTH  = 15;                 // word address into L2
    localparam int L2_AWIDTH_NOAL = L2_ADDR_WIDTH + 2;  // byte address
    localparam int TRANS_SIZE     = 17;
    localparam int DATA_WIDTH     = 32;
    localparam int APB_ADDR_WIDTH = 12;

    localparam logic [7:0] L2_ADDR_PREFIX = 8'h1C;

    localparam int TX_CREDITS    = 4;
    localparam int RX_FIFO_DEPTH = 4;
    localparam int TX_CNT_W      = $clog2(TX_CREDITS + 1);
    localparam int RX_PTR_W      = $clog2(RX_FIFO_DEPTH);

    localparam int N_EVENTS   = 2;
    localparam int EVT_RX_EOT = 0;
    localparam int EVT_TX_EOT = 1;

    typedef enum logic [APB_ADDR_WIDTH-1:0] {
        REG_RX_SADDR = 12'h000,
        REG_RX_SIZE  = 12'h004,
        REG_RX_CFG   = 12'h008,
        REG_TX_SADDR = 12'h010,
        REG_TX_SIZE  = 12'h014,
        REG_TX_CFG   = 12'h018
    } reg_offset_e;

    typedef enum logic {
        CH_IDLE = 1'b0,
        CH_RUN  = 1'b1
    } ch_state_e;

endpackage

// File: udma_apb_regs.sv
// no wait states; start pulse is combinational in the APB access phase and busy is not checked
`timescale 1ns/10ps

module udma_apb_regs (
    input  logic                                sys_clk_i,
    input  logic                                rst_n_i,
    input  logic [udma_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [udma_pkg::DATA_WIDTH-1:0]     pwdata_i,
    input  logic                                pwrite_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    output logic [udma_pkg::DATA_WIDTH-1:0]     prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    input  logic                                rx_busy_i,
    input  logic [udma_pkg::L2_AWIDTH_NOAL-1:0] rx_curr_addr_i,
    input  logic [udma_pkg::TRANS_SIZE-1:0]     rx_bytes_left_i,
    input  logic                                tx_busy_i,
    input  logic [udma_pkg::L2_AWIDTH_NOAL-1:0] tx_curr_addr_i,
    input  logic [udma_pkg::TRANS_SIZE-1:0]     tx_bytes_left_i,
    output logic [udma_pkg::L2_AWIDTH_NOAL-1:0] rx_cfg_startaddr_o,
    output logic [udma_pkg::TRANS_SIZE-1:0]     rx_cfg_size_o,
    output logic                                rx_cfg_continuous_o,
    output logic                                rx_start_o,
    output logic [udma_pkg::L2_AWIDTH_NOAL-1:0] tx_cfg_startaddr_o,
    output logic [udma_pkg::TRANS_SIZE-1:0]     tx_cfg_size_o,
    output logic                                tx_cfg_continuous_o,
    output logic                                tx_start_o
);
    import udma_pkg::*;

    logic access;
    logic wr_en;
    logic hit;

    assign access   = psel_i & penable_i;
    assign wr_en    = access & pwrite_i;
    assign pready_o = 1'b1;
    assign pslverr_o = access & ~hit;  // unmapped offset

    // status readback, progress rather than config
    always_comb begin
        hit      = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            REG_RX_SADDR: prdata_o[L2_AWIDTH_NOAL-1:0] = rx_curr_addr_i;
            REG_RX_SIZE:  prdata_o[TRANS_SIZE-1:0]     = rx_bytes_left_i;
            REG_RX_CFG:   prdata_o[4]                  = rx_busy_i;
            REG_TX_SADDR: prdata_o[L2_AWIDTH_NOAL-1:0] = tx_curr_addr_i;
            REG_TX_SIZE:  prdata_o[TRANS_SIZE-1:0]     = tx_bytes_left_i;
            REG_TX_CFG:   prdata_o[4]                  = tx_busy_i;
            default:      hit = 1'b0;
        endcase
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_cfg_startaddr_o  <= '0;
            rx_cfg_size_o       <= '0;
            rx_cfg_continuous_o <= 1'b0;
            tx_cfg_startaddr_o  <= '0;
            tx_cfg_size_o       <= '0;
            tx_cfg_continuous_o <= 1'b0;
        end else if (wr_en) begin
            case (paddr_i)
                REG_RX_SADDR: rx_cfg_startaddr_o  <= pwdata_i[L2_AWIDTH_NOAL-1:0];
                REG_RX_SIZE:  rx_cfg_size_o       <= pwdata_i[TRANS_SIZE-1:0];
                REG_RX_CFG:   rx_cfg_continuous_o <= pwdata_i[0];
                REG_TX_SADDR: tx_cfg_startaddr_o  <= pwdata_i[L2_AWIDTH_NOAL-1:0];
                REG_TX_SIZE:  tx_cfg_size_o       <= pwdata_i[TRANS_SIZE-1:0];
                REG_TX_CFG:   tx_cfg_continuous_o <= pwdata_i[0];
                default: ;
            endcase
        end
    end

    // enable bit
    assign rx_start_o = wr_en && (paddr_i == REG_RX_CFG) && pwdata_i[4];
    assign tx_start_o = wr_en && (paddr_i == REG_TX_CFG) && pwdata_i[4];

endmodule

// File: udma_tx_channel.sv
// sizes must be nonzero multiples of 4; credits persist across transfers and are never reset by start
`timescale 1ns/10ps

module udma_tx_channel (
    input  logic                                sys_clk_i,
    input  logic                                rst_n_i,
    input  logic [udma_pkg::L2_AWIDTH_NOAL-1:0] cfg_startaddr_i,
    input  logic [udma_pkg::TRANS_SIZE-1:0]     cfg_size_i,
    input  logic                                cfg_continuous_i,
    input  logic                                start_i,
    output logic                                l2_req_o,
    input  logic                                l2_gnt_i,
    output logic [udma_pkg::L2_ADDR_WIDTH-1:0]  l2_addr_o,
    input  logic                                l2_rvalid_i,
    input  logic [udma_pkg::DATA_WIDTH-1:0]     l2_rdata_i,
    output logic                                tx_valid_o,
    output logic [udma_pkg::DATA_WIDTH-1:0]     tx_data_o,
    input  logic                                tx_credit_i,
    output logic                                busy_o,
    output logic [udma_pkg::L2_AWIDTH_NOAL-1:0] curr_addr_o,
    output logic [udma_pkg::TRANS_SIZE-1:0]     bytes_left_o,
    output logic                                eot_o
);
    import udma_pkg::*;

    ch_state_e             state;
    logic [TX_CNT_W-1:0]   credits;
    logic [TX_CNT_W-1:0]   in_flight;  // granted, data not yet back
    logic                  grant;
    logic                  last_word;

    assign l2_req_o  = (state == CH_RUN) && (bytes_left_o != '0) && (credits != '0);
    assign grant     = l2_req_o & l2_gnt_i;
    assign last_word = l2_rvalid_i && (in_flight == TX_CNT_W'(1)) && (bytes_left_o == '0);
    assign l2_addr_o = curr_addr_o[L2_AWIDTH_NOAL-1:2];
    assign busy_o    = (state == CH_RUN);

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state        <= CH_IDLE;
            curr_addr_o  <= '0;
            bytes_left_o <= '0;
        end else begin
            case (state)
                CH_IDLE: begin
                    if (start_i) begin
                        state        <= CH_RUN;
                        curr_addr_o  <= cfg_startaddr_i;
                        bytes_left_o <= cfg_size_i;
                    end
                end
                CH_RUN: begin
                    if (grant) begin
                        curr_addr_o  <= curr_addr_o + L2_AWIDTH_NOAL'(4);
                        bytes_left_o <= (bytes_left_o > TRANS_SIZE'(4)) ?
                                        bytes_left_o - TRANS_SIZE'(4) : '0;
                    end else if (last_word) begin
                        if (cfg_continuous_i) begin  // next pass, stay busy
                            curr_addr_o  <= cfg_startaddr_i;
                            bytes_left_o <= cfg_size_i;
                        end else begin
                            state <= CH_IDLE;
                        end
                    end
                end
                default: state <= CH_IDLE;
            endcase
        end
    end

    // credit reserved at grant, returned by peripheral
    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credits   <= TX_CNT_W'(TX_CREDITS);
            in_flight <= '0;
        end else begin
            credits   <= credits - TX_CNT_W'(grant) + TX_CNT_W'(tx_credit_i);
            in_flight <= in_flight + TX_CNT_W'(grant) - TX_CNT_W'(l2_rvalid_i);
        end
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_valid_o <= 1'b0;
            eot_o      <= 1'b0;
        end else begin
            tx_valid_o <= l2_rvalid_i;
            eot_o      <= last_word;  // lines up with final tx_valid_o
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (l2_rvalid_i) begin
            tx_data_o <= l2_rdata_i;
        end
    end

endmodule

// File: udma_rx_channel.sv
// peripheral must respect credits, words beyond them are dropped; idle channel discards words
`timescale 1ns/10ps

module udma_rx_channel (
    input  logic                                sys_clk_i,
    input  logic                                rst_n_i,
    input  logic [udma_pkg::L2_AWIDTH_NOAL-1:0] cfg_startaddr_i,
    input  logic [udma_pkg::TRANS_SIZE-1:0]     cfg_size_i,
    input  logic                                cfg_continuous_i,
    input  logic                                start_i,
    output logic                                l2_req_o,
    input  logic                                l2_gnt_i,
    output logic [udma_pkg::L2_ADDR_WIDTH-1:0]  l2_addr_o,
    output logic [udma_pkg::DATA_WIDTH-1:0]     l2_wdata_o,
    input  logic                                rx_valid_i,
    input  logic [udma_pkg::DATA_WIDTH-1:0]     rx_data_i,
    output logic                                rx_credit_o,
    output logic                                busy_o,
    output logic [udma_pkg::L2_AWIDTH_NOAL-1:0] curr_addr_o,
    output logic [udma_pkg::TRANS_SIZE-1:0]     bytes_left_o,
    output logic                                eot_o
);
    import udma_pkg::*;

    ch_state_e             state;
    logic [DATA_WIDTH-1:0] fifo_mem [RX_FIFO_DEPTH];
    logic [RX_PTR_W:0]     wr_ptr;  // extra bit tells full from empty
    logic [RX_PTR_W:0]     rd_ptr;
    logic                  empty;
    logic                  full;
    logic                  push;
    logic                  pop;
    logic                  grant;
    logic                  last_word;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[RX_PTR_W] != rd_ptr[RX_PTR_W]) &&
                   (wr_ptr[RX_PTR_W-1:0] == rd_ptr[RX_PTR_W-1:0]);
    assign push  = rx_valid_i & ~full;

    assign l2_req_o   = (state == CH_RUN) & ~empty;
    assign grant      = l2_req_o & l2_gnt_i;
    assign pop        = grant | ((state == CH_IDLE) & ~empty);  // discard while idle
    assign last_word  = grant && (bytes_left_o <= TRANS_SIZE'(4));
    assign l2_wdata_o = fifo_mem[rd_ptr[RX_PTR_W-1:0]];
    assign l2_addr_o  = curr_addr_o[L2_AWIDTH_NOAL-1:2];
    assign busy_o     = (state == CH_RUN);

    always_ff @(posedge sys_clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr[RX_PTR_W-1:0]] <= rx_data_i;
        end
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            rx_credit_o <= 1'b0;
            eot_o       <= 1'b0;
        end else begin
            wr_ptr      <= wr_ptr + (RX_PTR_W + 1)'(push);
            rd_ptr      <= rd_ptr + (RX_PTR_W + 1)'(pop);
            rx_credit_o <= pop;  // one credit back per word leaving
            eot_o       <= last_word;
        end
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state        <= CH_IDLE;
            curr_addr_o  <= '0;
            bytes_left_o <= '0;
        end else begin
            case (state)
                CH_IDLE: begin
                    if (start_i) begin
                        state        <= CH_RUN;
                        curr_addr_o  <= cfg_startaddr_i;
                        bytes_left_o <= cfg_size_i;
                    end
                end
                CH_RUN: begin
                    if (last_word) begin
                        if (cfg_continuous_i) begin
                            curr_addr_o  <= cfg_startaddr_i;
                            bytes_left_o <= cfg_size_i;
                        end else begin
                            state        <= CH_IDLE;
                            curr_addr_o  <= curr_addr_o + L2_AWIDTH_NOAL'(4);
                            bytes_left_o <= '0;
                        end
                    end else if (grant) begin
                        curr_addr_o  <= curr_addr_o + L2_AWIDTH_NOAL'(4);
                        bytes_left_o <= bytes_left_o - TRANS_SIZE'(4);
                    end
                end
                default: state <= CH_IDLE;
            endcase
        end
    end

endmodule

// File: udma_subsystem.sv
// single clock; l2_wo_rvalid_i is not used, L2 addresses carry the fixed 8'h1C top byte
`timescale 1ns/10ps

module udma_subsystem (
    input  logic                                  sys_clk_i,
    input  logic                                  rst_n_i,
    input  logic [udma_pkg::APB_ADDR_WIDTH-1:0]   paddr_i,
    input  logic [udma_pkg::DATA_WIDTH-1:0]       pwdata_i,
    input  logic                                  pwrite_i,
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    output logic [udma_pkg::DATA_WIDTH-1:0]       prdata_o,
    output logic                                  pready_o,
    output logic                                  pslverr_o,
    output logic                                  l2_ro_req_o,
    input  logic                                  l2_ro_gnt_i,
    output logic                                  l2_ro_wen_o,
    output logic [31:0]                           l2_ro_addr_o,
    output logic [udma_pkg::DATA_WIDTH/8-1:0]     l2_ro_be_o,
    output logic [udma_pkg::DATA_WIDTH-1:0]       l2_ro_wdata_o,
    input  logic                                  l2_ro_rvalid_i,
    input  logic [udma_pkg::DATA_WIDTH-1:0]       l2_ro_rdata_i,
    output logic                                  l2_wo_req_o,
    input  logic                                  l2_wo_gnt_i,
    output logic                                  l2_wo_wen_o,
    output logic [31:0]                           l2_wo_addr_o,
    output logic [udma_pkg::DATA_WIDTH/8-1:0]     l2_wo_be_o,
    output logic [udma_pkg::DATA_WIDTH-1:0]       l2_wo_wdata_o,
    input  logic                                  l2_wo_rvalid_i,
    output logic [udma_pkg::N_EVENTS-1:0]         events_o,
    output logic                                  tx_valid_o,
    output logic [udma_pkg::DATA_WIDTH-1:0]       tx_data_o,
    input  logic                                  tx_credit_i,
    input  logic                                  rx_valid_i,
    input  logic [udma_pkg::DATA_WIDTH-1:0]       rx_data_i,
    output logic                                  rx_credit_o
);
    import udma_pkg::*;

    logic [L2_AWIDTH_NOAL-1:0] rx_cfg_startaddr, tx_cfg_startaddr;
    logic [TRANS_SIZE-1:0]     rx_cfg_size, tx_cfg_size;
    logic                      rx_cfg_continuous, tx_cfg_continuous;
    logic                      rx_start, tx_start;
    logic                      rx_busy, tx_busy;
    logic [L2_AWIDTH_NOAL-1:0] rx_curr_addr, tx_curr_addr;
    logic [TRANS_SIZE-1:0]     rx_bytes_left, tx_bytes_left;
    logic [L2_ADDR_WIDTH-1:0]  ro_word_addr, wo_word_addr;
    logic                      rx_eot, tx_eot;

    // prefix, zero pad, word address, byte offset
    assign l2_ro_addr_o = {L2_ADDR_PREFIX, {(32-L2_ADDR_WIDTH-10){1'b0}}, ro_word_addr, 2'b00};
    assign l2_wo_addr_o = {L2_ADDR_PREFIX, {(32-L2_ADDR_WIDTH-10){1'b0}}, wo_word_addr, 2'b00};

    assign l2_ro_wen_o   = 1'b1;  // read only
    assign l2_ro_be_o    = '0;
    assign l2_ro_wdata_o = '0;
    assign l2_wo_wen_o   = 1'b0;
    assign l2_wo_be_o    = '1;    // full words only

    assign events_o[EVT_RX_EOT] = rx_eot;
    assign events_o[EVT_TX_EOT] = tx_eot;

    udma_apb_regs u_regs (
        .sys_clk_i, .rst_n_i, .paddr_i, .pwdata_i, .pwrite_i, .psel_i, .penable_i,
        .prdata_o, .pready_o, .pslverr_o,
        .rx_busy_i(rx_busy), .rx_curr_addr_i(rx_curr_addr), .rx_bytes_left_i(rx_bytes_left),
        .tx_busy_i(tx_busy), .tx_curr_addr_i(tx_curr_addr), .tx_bytes_left_i(tx_bytes_left),
        .rx_cfg_startaddr_o(rx_cfg_startaddr), .rx_cfg_size_o(rx_cfg_size),
        .rx_cfg_continuous_o(rx_cfg_continuous), .rx_start_o(rx_start),
        .tx_cfg_startaddr_o(tx_cfg_startaddr), .tx_cfg_size_o(tx_cfg_size),
        .tx_cfg_continuous_o(tx_cfg_continuous), .tx_start_o(tx_start)
    );

    udma_tx_channel u_tx (
        .sys_clk_i, .rst_n_i,
        .cfg_startaddr_i(tx_cfg_startaddr), .cfg_size_i(tx_cfg_size),
        .cfg_continuous_i(tx_cfg_continuous), .start_i(tx_start),
        .l2_req_o(l2_ro_req_o), .l2_gnt_i(l2_ro_gnt_i), .l2_addr_o(ro_word_addr),
        .l2_rvalid_i(l2_ro_rvalid_i), .l2_rdata_i(l2_ro_rdata_i),
        .tx_valid_o, .tx_data_o, .tx_credit_i,
        .busy_o(tx_busy), .curr_addr_o(tx_curr_addr), .bytes_left_o(tx_bytes_left),
        .eot_o(tx_eot)
    );

    udma_rx_channel u_rx (
        .sys_clk_i, .rst_n_i,
        .cfg_startaddr_i(rx_cfg_startaddr), .cfg_size_i(rx_cfg_size),
        .cfg_continuous_i(rx_cfg_continuous), .start_i(rx_start),
        .l2_req_o(l2_wo_req_o), .l2_gnt_i(l2_wo_gnt_i), .l2_addr_o(wo_word_addr),
        .l2_wdata_o(l2_wo_wdata_o),
        .rx_valid_i, .rx_data_i, .rx_credit_o,
        .busy_o(rx_busy), .curr_addr_o(rx_curr_addr), .bytes_left_o(rx_bytes_left),
        .eot_o(rx_eot)
    );

endmodule

// File: udma_properties.sv
// bound to udma_subsystem; assumes the tx sink returns one credit per received word
`timescale 1ns/10ps

module udma_properties (
    input logic                            sys_clk_i,
    input logic                            rst_n_i,
    input logic                            ro_req_i,
    input logic                            ro_gnt_i,
    input logic [31:0]                     ro_addr_i,
    input logic                            wo_req_i,
    input logic                            wo_gnt_i,
    input logic [31:0]                     wo_addr_i,
    input logic [udma_pkg::DATA_WIDTH-1:0] wo_wdata_i,
    input logic                            tx_credit_i,
    input logic                            rx_valid_i,
    input logic                            rx_credit_i,
    input logic [udma_pkg::N_EVENTS-1:0]   events_i
);
    import udma_pkg::*;

    logic [3:0] tx_out;  // granted reads not yet credited back
    logic [3:0] rx_out;  // words sent not yet credited back

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_out <= '0;
            rx_out <= '0;
        end else begin
            tx_out <= tx_out + 4'(ro_req_i & ro_gnt_i) - 4'(tx_credit_i);
            rx_out <= rx_out + 4'(rx_valid_i) - 4'(rx_credit_i);
        end
    end

    ro_hold: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        ro_req_i && !ro_gnt_i |=> ro_req_i && $stable(ro_addr_i))
        else $error("L2 read request dropped or address changed before gnt");

    wo_hold: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        wo_req_i && !wo_gnt_i |=> wo_req_i && $stable(wo_addr_i) && $stable(wo_wdata_i))
        else $error("L2 write request changed before gnt");

    tx_credit_limit: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        tx_out <= TX_CREDITS)
        else $error("TX words in flight exceed the credits");

    rx_credit_limit: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        rx_out <= RX_FIFO_DEPTH)
        else $error("RX words sent beyond the credits granted");

    rx_evt_pulse: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        events_i[EVT_RX_EOT] |=> !events_i[EVT_RX_EOT])
        else $error("RX end of transfer event longer than one cycle");

    tx_evt_pulse: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        events_i[EVT_TX_EOT] |=> !events_i[EVT_TX_EOT])
        else $error("TX end of transfer event longer than one cycle");

endmodule

bind udma_subsystem udma_properties u_props (
    .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i),
    .ro_req_i(l2_ro_req_o), .ro_gnt_i(l2_ro_gnt_i), .ro_addr_i(l2_ro_addr_o),
    .wo_req_i(l2_wo_req_o), .wo_gnt_i(l2_wo_gnt_i), .wo_addr_i(l2_wo_addr_o),
    .wo_wdata_i(l2_wo_wdata_o), .tx_credit_i(tx_credit_i),
    .rx_valid_i(rx_valid_i), .rx_credit_i(rx_credit_o), .events_i(events_o)
);

// File: tb_udma_subsystem.sv
// L2 model aliases every 4 KiB; the run is bounded by a watchdog sized from the total word count
`timescale 1ns/10ps

module tb_udma_subsystem;
    import udma_pkg::*;

    localparam int TOTAL_WORDS    = 8 + 8 + 16 + 6 + 16;
    localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 40;

    logic        sys_clk_i;
    logic        rst_n_i;
    logic [11:0] paddr_i;
    logic [31:0] pwdata_i;
    logic        pwrite_i, psel_i, penable_i;
    logic [31:0] prdata_o;
    logic        pready_o, pslverr_o;
    logic        l2_ro_req_o, l2_ro_gnt_i, l2_ro_wen_o, l2_ro_rvalid_i;
    logic [31:0] l2_ro_addr_o, l2_ro_wdata_o, l2_ro_rdata_i;
    logic [3:0]  l2_ro_be_o, l2_wo_be_o;
    logic        l2_wo_req_o, l2_wo_gnt_i, l2_wo_wen_o, l2_wo_rvalid_i;
    logic [31:0] l2_wo_addr_o, l2_wo_wdata_o;
    logic [1:0]  events_o;
    logic        tx_valid_o, tx_credit_i, rx_valid_i, rx_credit_o;
    logic [31:0] tx_data_o, rx_data_i;

    logic [31:0] mem [1024];
    logic [31:0] rng;
    logic [31:0] data_rng;
    logic [7:0]  stall_level;   // gnt when random byte >= this
    logic        hold_credits;
    logic [31:0] tx_words [$];
    logic [31:0] rx_send_q [$];
    int          owed;          // tx credits not yet returned
    int          rx_cred;
    int          rx_credit_seen;
    int          tx_eot_cnt, rx_eot_cnt;
    bit          fail_seen, run_passed;

    // values seen at the falling edge, used at the next rising edge
    logic        s_ro_fire, s_wo_fire, s_tx_valid, s_rx_credit;
    logic [9:0]  s_ro_idx, s_wo_idx;
    logic [31:0] s_wo_data, s_tx_data;
    logic [1:0]  s_evt;

    udma_subsystem uut (.*);

    always #50 sys_clk_i = ~sys_clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] word_pattern(input logic [31:0] n);
        return (n * 32'h9e37_79b9) ^ {n[15:0], ~n[15:0]};
    endfunction

    task automatic expect_true(input logic ok, input string msg);
        assert (ok) else begin
            $display("error at %0t ns: %s", $time, msg);
            fail_seen = 1'b1;
            $display("*** FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge sys_clk_i);
        paddr_i   <= addr;
        pwdata_i  <= data;
        pwrite_i  <= 1'b1;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge sys_clk_i);
        penable_i <= 1'b1;
        @(posedge sys_clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge sys_clk_i);
        paddr_i   <= addr;
        pwrite_i  <= 1'b0;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge sys_clk_i);
        penable_i <= 1'b1;
        @(negedge sys_clk_i);
        data = prdata_o;
        err  = pslverr_o;
        expect_true(pready_o == 1'b1, "pready low in access phase");
        @(posedge sys_clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    always @(negedge sys_clk_i) begin
        s_ro_fire   <= l2_ro_req_o & l2_ro_gnt_i;
        s_ro_idx    <= l2_ro_addr_o[11:2];
        s_wo_fire   <= l2_wo_req_o & l2_wo_gnt_i;
        s_wo_idx    <= l2_wo_addr_o[11:2];
        s_wo_data   <= l2_wo_wdata_o;
        s_tx_valid  <= tx_valid_o;
        s_tx_data   <= tx_data_o;
        s_rx_credit <= rx_credit_o;
        s_evt       <= events_o;
        if (rst_n_i && l2_ro_req_o) begin
            expect_true(l2_ro_addr_o[31:24] == L2_ADDR_PREFIX, "read address prefix");
            expect_true(l2_ro_wen_o && l2_ro_be_o == 4'h0 && l2_ro_wdata_o == 32'h0,
                        "read port write enable, byte enables or data");
        end
        if (rst_n_i && l2_wo_req_o) begin
            expect_true(l2_wo_addr_o[31:24] == L2_ADDR_PREFIX, "write address prefix");
            expect_true(!l2_wo_wen_o && l2_wo_be_o == 4'hf,
                        "write port write enable or byte enables");
        end
    end

    // L2 ports, tx sink and rx source
    always @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 1024; i++)
                mem[i] = word_pattern(i);
            l2_ro_gnt_i    <= 1'b0;
            l2_ro_rvalid_i <= 1'b0;
            l2_wo_gnt_i    <= 1'b0;
            tx_credit_i    <= 1'b0;
            rx_valid_i     <= 1'b0;
        end else begin
            l2_ro_rvalid_i <= s_ro_fire;  // one cycle after gnt
            l2_ro_rdata_i  <= mem[s_ro_idx];
            if (s_wo_fire)
                mem[s_wo_idx] = s_wo_data;
            rng = xorshift32(rng);
            l2_ro_gnt_i <= (rng[7:0] >= stall_level);
            l2_wo_gnt_i <= (rng[15:8] >= stall_level);
            if (s_tx_valid) begin
                tx_words.push_back(s_tx_data);
                owed++;
            end
            if (!hold_credits && owed > 0 && rng[16]) begin
                tx_credit_i <= 1'b1;
                owed--;
            end else begin
                tx_credit_i <= 1'b0;
            end
            if (s_rx_credit) begin
                rx_cred++;
                rx_credit_seen++;
            end
            if (rx_send_q.size() > 0 && rx_cred > 0 && rng[17]) begin
                rx_valid_i <= 1'b1;
                rx_data_i  <= rx_send_q.pop_front();
                rx_cred--;
            end else begin
                rx_valid_i <= 1'b0;
            end
            if (s_evt[EVT_TX_EOT]) tx_eot_cnt++;
            if (s_evt[EVT_RX_EOT]) rx_eot_cnt++;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge sys_clk_i);
        $display("timeout: transfers did not finish within %0d cycles", TIMEOUT_CYCLES);
        fail_seen = 1'b1;
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    final begin
        if (!run_passed && !fail_seen)
            $display("*** FAILED ***");  // stopped by a bound assertion
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [31:0] rx_exp [$];
        int          base;
        int          n;
        sys_clk_i = 1'b0;
        rst_n_i   = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        pwrite_i  = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        l2_ro_gnt_i = 1'b0;
        l2_ro_rvalid_i = 1'b0;
        l2_ro_rdata_i = '0;
        l2_wo_gnt_i = 1'b0;
        l2_wo_rvalid_i = 1'b0;
        tx_credit_i = 1'b0;
        rx_valid_i = 1'b0;
        rx_data_i = '0;
        rng = 32'h41e8_666f;
        data_rng = 32'h41e8_666f;
        stall_level = 8'd64;
        hold_credits = 1'b0;
        owed = 0;
        rx_cred = RX_FIFO_DEPTH;
        rx_credit_seen = 0;
        tx_eot_cnt = 0;
        rx_eot_cnt = 0;
        repeat (4) @(posedge sys_clk_i);
        rst_n_i <= 1'b1;

        // readback shows channel progress, still reset values while idle
        apb_write(REG_RX_SADDR, 32'h0000_0200);
        apb_write(REG_RX_SIZE, 32'd64);
        apb_read(REG_RX_SADDR, rd, err);
        expect_true(rd == 32'h0 && !err, "idle rx current address");
        apb_read(REG_RX_SIZE, rd, err);
        expect_true(rd == 32'h0 && !err, "idle rx bytes left");
        apb_read(REG_RX_CFG, rd, err);
        expect_true(rd[4] == 1'b0, "rx busy after reset");
        apb_read(12'h020, rd, err);
        expect_true(err && rd == 32'h0, "unmapped offset response");

        // plain TX from word 64
        apb_write(REG_TX_SADDR, 32'h0000_0100);
        apb_write(REG_TX_SIZE, 32'd32);
        apb_write(REG_TX_CFG, 32'h10);
        while (tx_eot_cnt < 1) @(posedge sys_clk_i);
        repeat (5) @(posedge sys_clk_i);
        expect_true(tx_eot_cnt == 1 && tx_words.size() == 8, "tx word and eot count");
        for (int i = 0; i < 8; i++)
            expect_true(tx_words[i] == word_pattern(64 + i), "tx data");
        apb_read(REG_TX_CFG, rd, err);
        expect_true(rd[4] == 1'b0, "tx busy after eot");
        apb_read(REG_TX_SIZE, rd, err);
        expect_true(rd == 32'h0, "tx bytes left after eot");
        apb_read(REG_TX_SADDR, rd, err);
        expect_true(rd == 32'h120, "tx current address after eot");

        // RX of random words to word 256
        apb_write(REG_RX_SADDR, 32'h0000_0400);
        apb_write(REG_RX_SIZE, 32'd32);
        apb_write(REG_RX_CFG, 32'h10);
        for (int i = 0; i < 8; i++) begin
            data_rng = xorshift32(data_rng);
            rx_exp.push_back(data_rng);
            rx_send_q.push_back(data_rng);
        end
        while (rx_eot_cnt < 1) @(posedge sys_clk_i);
        repeat (5) @(posedge sys_clk_i);
        expect_true(rx_eot_cnt == 1, "rx eot count");
        for (int i = 0; i < 8; i++)
            expect_true(mem[256 + i] == rx_exp[i], "rx data in L2");

        // credits withheld, heavy stalls
        while (owed != 0) @(posedge sys_clk_i);
        tx_words.delete();
        hold_credits = 1'b1;
        stall_level = 8'd192;
        apb_write(REG_TX_SADDR, 32'h0000_0800);
        apb_write(REG_TX_SIZE, 32'd64);
        apb_write(REG_TX_CFG, 32'h10);
        repeat (200) @(posedge sys_clk_i);
        expect_true(tx_words.size() <= TX_CREDITS, "tx words beyond credits");
        hold_credits = 1'b0;
        while (tx_eot_cnt < 2) @(posedge sys_clk_i);
        repeat (5) @(posedge sys_clk_i);
        expect_true(tx_words.size() == 16, "tx word count under back-pressure");
        for (int i = 0; i < 16; i++)
            expect_true(tx_words[i] == word_pattern(512 + i), "tx data under back-pressure");
        stall_level = 8'd64;

        // idle RX drops words but returns credits
        base = rx_credit_seen;
        for (int i = 0; i < 6; i++)
            rx_send_q.push_back(32'hdead_0000 + i);
        while (rx_credit_seen < base + 6) @(posedge sys_clk_i);
        repeat (5) @(posedge sys_clk_i);
        expect_true(rx_credit_seen == base + 6 && rx_cred == RX_FIFO_DEPTH, "idle rx credits");

        // continuous TX, stopped by clearing the mode bit
        tx_words.delete();
        base = tx_eot_cnt;
        apb_write(REG_TX_SADDR, 32'h0000_0040);
        apb_write(REG_TX_SIZE, 32'd16);
        apb_write(REG_TX_CFG, 32'h11);
        while (tx_eot_cnt < base + 2) @(posedge sys_clk_i);
        apb_read(REG_TX_CFG, rd, err);
        expect_true(rd[4] == 1'b1, "tx busy in continuous mode");
        apb_write(REG_TX_CFG, 32'h0);
        rd = 32'h10;
        while (rd[4]) apb_read(REG_TX_CFG, rd, err);
        repeat (5) @(posedge sys_clk_i);
        n = tx_words.size();
        expect_true(n >= 8 && n % 4 == 0, "continuous word count");
        expect_true(tx_eot_cnt - base == n / 4, "one eot per pass");
        for (int i = 0; i < n; i++)
            expect_true(tx_words[i] == word_pattern(16 + i % 4), "continuous pass data");

        run_passed = 1'b1;
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: build.f
udma_pkg.sv
udma_apb_regs.sv
udma_tx_channel.sv
udma_rx_channel.sv
udma_subsystem.sv
udma_properties.sv
tb_udma_subsystem.sv

// File: Makefile
SHELL := /bin/bash

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_udma_subsystem -f build.f -o Vtb

run: compile
	set -o pipefail; ./obj_dir/Vtb | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then \
		echo "simulation failed"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log
